/* common/arm_params.svh */
`ifndef ARM_PARAMS_SVH
`define ARM_PARAMS_SVH

// Datapath widths
`define WORD_W      32
`define REG_AW      4
`define REG_N       16

// First fetch address out of reset
`define RESET_PC    32'h0000_0000

// Bit positions in the 4-bit NZCV word
`define FLAG_N      3
`define FLAG_Z      2
`define FLAG_C      1
`define FLAG_V      0

`endif

/* common/armPkg.sv */
package armPkg;

    typedef enum logic [3:0] {
        condEq, condNe, condCs, condCc,
        condMi, condPl, condVs, condVc,
        condHi, condLs, condGe, condLt,
        condGt, condLe, condAl
    } condCode;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOrr, aluMov} aluOp;

    typedef enum logic [1:0] {fwdReg, fwdWb, fwdMem} fwdSel;

    // Data processing, Rm is the low nibble of imm8 in the register form
    typedef struct packed {
        condCode    cond;
        logic [1:0] op;
        logic       immBit;
        logic [3:0] cmd;
        logic       sBit;
        logic [3:0] rn;
        logic [3:0] rd;
        logic [3:0] rot;
        logic [7:0] imm8;
    } dpFields;

    // Low 24 bits, read whole as the branch offset
    typedef struct packed {
        logic [2:0]  ubw;
        logic        load;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] imm12;
    } mbOffset;

    typedef struct packed {
        condCode    cond;
        logic [1:0] op;
        logic [1:0] funct;
        mbOffset    offset;
    } mbFields;

    typedef union packed {
        dpFields dp;
        mbFields mb;
    } instrWord;

endpackage

/* rtl/decodeUnit.sv */
`include "arm_params.svh"

module decodeUnit (
    input  armPkg::instrWord    instr,
    output logic [`REG_AW-1:0]  ra1,
    output logic [`REG_AW-1:0]  ra2,
    output logic [`REG_AW-1:0]  wa3,
    output logic [`WORD_W-1:0]  extImm,
    output logic                aluSrcImm,
    output armPkg::aluOp        alu,
    output logic                regW,
    output logic                memW,
    output logic                memToReg,
    output logic                branch,
    output logic                flagW,
    output logic                noWrite,
    output armPkg::condCode     cond
);
    import armPkg::*;

    // R15 is never written, so it marks an unused source
    localparam logic [`REG_AW-1:0] noReg = `REG_AW'(`REG_N - 1);

    assign cond = instr.dp.cond;

    always_comb begin
        ra1       = instr.dp.rn;
        ra2       = instr.dp.imm8[3:0];
        wa3       = instr.dp.rd;
        extImm    = `WORD_W'(instr.dp.imm8);
        aluSrcImm = instr.dp.immBit;
        alu       = aluAdd;
        regW      = 1'b0;
        memW      = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        flagW     = 1'b0;
        noWrite   = 1'b0;
        case (instr.dp.op)
            2'b00: begin
                regW  = 1'b1;
                flagW = instr.dp.sBit;
                if (instr.dp.immBit) begin
                    ra2 = noReg;
                end
                case (instr.dp.cmd)
                    4'b0100: alu = aluAdd;
                    4'b0010: alu = aluSub;
                    4'b0000: alu = aluAnd;
                    4'b1100: alu = aluOrr;
                    4'b1101: begin
                        alu = aluMov;
                        ra1 = noReg;
                    end
                    // CMP
                    4'b1010: begin
                        alu     = aluSub;
                        noWrite = 1'b1;
                        flagW   = 1'b1;
                    end
                    default: regW = 1'b0;
                endcase
            end
            2'b01: begin
                aluSrcImm = 1'b1;
                extImm    = `WORD_W'(instr.mb.offset.imm12);
                memToReg  = instr.mb.offset.load;
                regW      = instr.mb.offset.load;
                memW      = ~instr.mb.offset.load;
                // Store data comes from Rd
                ra2       = instr.mb.offset.load ? noReg : instr.mb.offset.rd;
            end
            2'b10: begin
                ra1       = noReg;
                ra2       = noReg;
                aluSrcImm = 1'b1;
                branch    = 1'b1;
                extImm    = {{(`WORD_W - 26){instr.mb.offset[23]}}, instr.mb.offset, 2'b00};
            end
            default: regW = 1'b0;
        endcase
    end

endmodule

/* rtl/regFile.sv */
`include "arm_params.svh"

module regFile (
    input  logic                CLK,
    input  logic                rstN,
    input  logic [`REG_AW-1:0]  ra1,
    input  logic [`REG_AW-1:0]  ra2,
    input  logic [`REG_AW-1:0]  wa3,
    input  logic                we3,
    input  logic [`WORD_W-1:0]  wd3,
    output logic [`WORD_W-1:0]  rd1,
    output logic [`WORD_W-1:0]  rd2
);

    logic [`WORD_W-1:0] regs [`REG_N];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (we3) begin
            regs[wa3] <= wd3;
        end
    end

    // Writeback in the same cycle is seen by decode
    assign rd1 = (we3 && wa3 == ra1) ? wd3 : regs[ra1];
    assign rd2 = (we3 && wa3 == ra2) ? wd3 : regs[ra2];

endmodule

/* rtl/condUnit.sv */
`include "arm_params.svh"

module condUnit (
    input  logic            CLK,
    input  logic            rstN,
    input  armPkg::condCode cond,
    input  logic [3:0]      aluFlags,
    input  logic            flagW,
    input  logic            regW,
    input  logic            memW,
    input  logic            branch,
    input  logic            noWrite,
    output logic            regWrite,
    output logic            memWrite,
    output logic            pcSrc
);
    import armPkg::*;

    logic [3:0] flags;
    logic       n;
    logic       z;
    logic       c;
    logic       v;
    logic       condEx;

    assign n = flags[`FLAG_N];
    assign z = flags[`FLAG_Z];
    assign c = flags[`FLAG_C];
    assign v = flags[`FLAG_V];

    always_comb begin
        case (cond)
            condEq:  condEx = z;
            condNe:  condEx = ~z;
            condCs:  condEx = c;
            condCc:  condEx = ~c;
            condMi:  condEx = n;
            condPl:  condEx = ~n;
            condVs:  condEx = v;
            condVc:  condEx = ~v;
            condHi:  condEx = c & ~z;
            condLs:  condEx = ~c | z;
            condGe:  condEx = (n == v);
            condLt:  condEx = (n != v);
            condGt:  condEx = ~z & (n == v);
            condLe:  condEx = z | (n != v);
            default: condEx = 1'b1;
        endcase
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
        end else if (flagW && condEx) begin
            flags <= aluFlags;
        end
    end

    assign regWrite = regW & condEx & ~noWrite;
    assign memWrite = memW & condEx;
    assign pcSrc    = branch & condEx;

endmodule

/* rtl/alu.sv */
`include "arm_params.svh"

module alu (
    input  logic [`WORD_W-1:0]  srcA,
    input  logic [`WORD_W-1:0]  srcB,
    input  armPkg::aluOp        op,
    output logic [`WORD_W-1:0]  result,
    output logic [3:0]          flags
);
    import armPkg::*;

    logic               isSub;
    logic               isArith;
    logic [`WORD_W-1:0] opB;
    logic [`WORD_W:0]   sum;

    assign isSub   = (op == aluSub);
    assign isArith = (op == aluAdd) || isSub;
    assign opB     = isSub ? ~srcB : srcB;
    assign sum     = {1'b0, srcA} + {1'b0, opB} + `WORD_W'(isSub);

    always_comb begin
        case (op)
            aluAdd, aluSub: result = sum[`WORD_W-1:0];
            aluAnd:         result = srcA & srcB;
            aluOrr:         result = srcA | srcB;
            default:        result = srcB;
        endcase
    end

    assign flags[`FLAG_N] = result[`WORD_W-1];
    assign flags[`FLAG_Z] = (result == '0);
    assign flags[`FLAG_C] = isArith & sum[`WORD_W];
    // Same-sign operands giving a result of the other sign
    assign flags[`FLAG_V] = isArith & (srcA[`WORD_W-1] == opB[`WORD_W-1])
                          & (result[`WORD_W-1] != srcA[`WORD_W-1]);

endmodule

/* rtl/hazardUnit.sv */
`include "arm_params.svh"

module hazardUnit (
    input  logic [`REG_AW-1:0]  ra1D,
    input  logic [`REG_AW-1:0]  ra2D,
    input  logic [`REG_AW-1:0]  ra1E,
    input  logic [`REG_AW-1:0]  ra2E,
    input  logic [`REG_AW-1:0]  wa3E,
    input  logic [`REG_AW-1:0]  wa3M,
    input  logic [`REG_AW-1:0]  wa3W,
    input  logic                regWriteM,
    input  logic                regWriteW,
    input  logic                memToRegE,
    input  logic                pcSrcE,
    output armPkg::fwdSel       forwardA,
    output armPkg::fwdSel       forwardB,
    output logic                stallF,
    output logic                stallD,
    output logic                flushD,
    output logic                flushE
);
    import armPkg::*;

    logic ldStall;

    // Youngest producer wins
    function automatic fwdSel pickSrc(input logic [`REG_AW-1:0] ra);
        if (regWriteM && wa3M == ra) begin
            return fwdMem;
        end
        if (regWriteW && wa3W == ra) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign forwardA = pickSrc(ra1E);
    assign forwardB = pickSrc(ra2E);

    assign ldStall = memToRegE && (wa3E == ra1D || wa3E == ra2D);

    assign stallF = ldStall;
    assign stallD = ldStall;
    assign flushD = pcSrcE;
    assign flushE = ldStall | pcSrcE;

endmodule

/* rtl/armCore.sv */
`include "arm_params.svh"

module armCore (
    input  logic                CLK,
    input  logic                rstN,
    output logic [`WORD_W-1:0]  instrAddr,
    input  logic [`WORD_W-1:0]  instr,
    output logic [`WORD_W-1:0]  dataAddr,
    output logic [`WORD_W-1:0]  dataWrite,
    output logic                dataWe,
    output logic                dataRe,
    input  logic [`WORD_W-1:0]  dataRead
);
    import armPkg::*;

    logic [`WORD_W-1:0] pcF;
    logic [`WORD_W-1:0] pcPlus4F;

    instrWord           instrD;
    logic               validD;
    logic               killD;
    logic [`REG_AW-1:0] ra1D;
    logic [`REG_AW-1:0] ra2D;
    logic [`REG_AW-1:0] wa3D;
    logic [`WORD_W-1:0] extImmD;
    logic [`WORD_W-1:0] rd1D;
    logic [`WORD_W-1:0] rd2D;
    logic [`WORD_W-1:0] pcPlus8D;
    logic               aluSrcImmD;
    logic               regWD;
    logic               memWD;
    logic               memToRegD;
    logic               branchD;
    logic               flagWD;
    logic               noWriteD;
    aluOp               aluD;
    condCode            condD;

    logic [`REG_AW-1:0] ra1E;
    logic [`REG_AW-1:0] ra2E;
    logic [`REG_AW-1:0] wa3E;
    logic [`WORD_W-1:0] extImmE;
    logic [`WORD_W-1:0] rd1E;
    logic [`WORD_W-1:0] rd2E;
    logic [`WORD_W-1:0] pcPlus8E;
    logic               aluSrcImmE;
    logic               regWE;
    logic               memWE;
    logic               memToRegE;
    logic               branchE;
    logic               flagWE;
    logic               noWriteE;
    aluOp               aluE;
    condCode            condE;
    logic [`WORD_W-1:0] srcAE;
    logic [`WORD_W-1:0] srcBE;
    logic [`WORD_W-1:0] writeDataE;
    logic [`WORD_W-1:0] aluResultE;
    logic [3:0]         aluFlagsE;
    logic               regWriteE;
    logic               memWriteE;
    logic               pcSrcE;

    logic               regWriteM;
    logic               memWriteM;
    logic               memToRegM;
    logic [`REG_AW-1:0] wa3M;
    logic [`WORD_W-1:0] aluOutM;
    logic [`WORD_W-1:0] writeDataM;

    logic               regWriteW;
    logic               memToRegW;
    logic [`REG_AW-1:0] wa3W;
    logic [`WORD_W-1:0] aluOutW;
    logic [`WORD_W-1:0] readDataW;
    logic [`WORD_W-1:0] resultW;

    fwdSel              forwardA;
    fwdSel              forwardB;
    logic               stallF;
    logic               stallD;
    logic               flushD;
    logic               flushE;

    function automatic logic [`WORD_W-1:0] fwdMux(input fwdSel sel,
                                                  input logic [`WORD_W-1:0] regVal);
        case (sel)
            fwdMem:  return aluOutM;
            fwdWb:   return resultW;
            default: return regVal;
        endcase
    endfunction

    //////////////////////////////
    // Fetch
    //////////////////////////////

    assign pcPlus4F  = pcF + `WORD_W'(4);
    assign instrAddr = pcF;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pcF <= `RESET_PC;
        end else if (!stallF) begin
            pcF <= pcSrcE ? aluResultE : pcPlus4F;
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            validD <= 1'b0;
        end else if (flushD) begin
            validD <= 1'b0;
        end else if (!stallD) begin
            validD <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stallD) begin
            instrD <= instr;
        end
    end

    // Fetch PC+4 equals decode PC+8 while both stages move together
    assign pcPlus8D = pcPlus4F;

    //////////////////////////////
    // Decode
    //////////////////////////////

    decodeUnit uDecode (
        .instr     (instrD),
        .ra1       (ra1D),
        .ra2       (ra2D),
        .wa3       (wa3D),
        .extImm    (extImmD),
        .aluSrcImm (aluSrcImmD),
        .alu       (aluD),
        .regW      (regWD),
        .memW      (memWD),
        .memToReg  (memToRegD),
        .branch    (branchD),
        .flagW     (flagWD),
        .noWrite   (noWriteD),
        .cond      (condD)
    );

    regFile uRegs (
        .CLK  (CLK),
        .rstN (rstN),
        .ra1  (ra1D),
        .ra2  (ra2D),
        .wa3  (wa3W),
        .we3  (regWriteW),
        .wd3  (resultW),
        .rd1  (rd1D),
        .rd2  (rd2D)
    );

    assign killD = flushE | ~validD;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            {regWE, memWE, memToRegE, branchE, flagWE} <= '0;
        end else begin
            {regWE, memWE, memToRegE, branchE, flagWE} <=
                killD ? '0 : {regWD, memWD, memToRegD, branchD, flagWD};
        end
    end

    always_ff @(posedge CLK) begin
        ra1E       <= ra1D;
        ra2E       <= ra2D;
        wa3E       <= wa3D;
        extImmE    <= extImmD;
        rd1E       <= rd1D;
        rd2E       <= rd2D;
        pcPlus8E   <= pcPlus8D;
        aluSrcImmE <= aluSrcImmD;
        noWriteE   <= noWriteD;
        aluE       <= aluD;
        condE      <= condD;
    end

    //////////////////////////////
    // Execute
    //////////////////////////////

    assign srcAE      = branchE ? pcPlus8E : fwdMux(forwardA, rd1E);
    assign writeDataE = fwdMux(forwardB, rd2E);
    assign srcBE      = aluSrcImmE ? extImmE : writeDataE;

    alu uAlu (
        .srcA   (srcAE),
        .srcB   (srcBE),
        .op     (aluE),
        .result (aluResultE),
        .flags  (aluFlagsE)
    );

    condUnit uCond (
        .CLK      (CLK),
        .rstN     (rstN),
        .cond     (condE),
        .aluFlags (aluFlagsE),
        .flagW    (flagWE),
        .regW     (regWE),
        .memW     (memWE),
        .branch   (branchE),
        .noWrite  (noWriteE),
        .regWrite (regWriteE),
        .memWrite (memWriteE),
        .pcSrc    (pcSrcE)
    );

    hazardUnit uHazard (
        .ra1D      (ra1D),
        .ra2D      (ra2D),
        .ra1E      (ra1E),
        .ra2E      (ra2E),
        .wa3E      (wa3E),
        .wa3M      (wa3M),
        .wa3W      (wa3W),
        .regWriteM (regWriteM),
        .regWriteW (regWriteW),
        .memToRegE (memToRegE),
        .pcSrcE    (pcSrcE),
        .forwardA  (forwardA),
        .forwardB  (forwardB),
        .stallF    (stallF),
        .stallD    (stallD),
        .flushD    (flushD),
        .flushE    (flushE)
    );

    //////////////////////////////
    // Memory and writeback
    //////////////////////////////

    // A load whose condition failed issues no read
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            {regWriteM, memWriteM, memToRegM} <= '0;
        end else begin
            {regWriteM, memWriteM, memToRegM} <= {regWriteE, memWriteE, memToRegE & regWriteE};
        end
    end

    always_ff @(posedge CLK) begin
        wa3M       <= wa3E;
        aluOutM    <= aluResultE;
        writeDataM <= writeDataE;
    end

    assign dataAddr  = aluOutM;
    assign dataWrite = writeDataM;
    assign dataWe    = memWriteM;
    assign dataRe    = memToRegM;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            regWriteW <= 1'b0;
        end else begin
            regWriteW <= regWriteM;
        end
    end

    always_ff @(posedge CLK) begin
        memToRegW <= memToRegM;
        wa3W      <= wa3M;
        aluOutW   <= aluOutM;
        readDataW <= dataRead;
    end

    assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

/* verification/coreChecker.sv */
`include "arm_params.svh"

module coreChecker #(
    parameter int depth = 64
) (
    input  logic                CLK,
    input  logic                rstN,
    input  logic [`WORD_W-1:0]  dataAddr,
    input  logic [`WORD_W-1:0]  dataWrite,
    input  logic                dataWe,
    input  logic                dataRe,
    input  logic [`WORD_W-1:0]  expAddr [depth],
    input  logic [`WORD_W-1:0]  expData [depth],
    input  int                  expCount,
    input  logic [`WORD_W-1:0]  expLoadAddr,
    input  int                  expLoadCount,
    output int                  seenCount,
    output int                  mismatchCount,
    output int                  extraCount,
    output int                  missingCount
);

    int loadCount;

    // Data port outputs settle after the rising edge
    always @(negedge CLK) begin
        if (!rstN) begin
            seenCount     = 0;
            loadCount     = 0;
            mismatchCount = 0;
            extraCount    = 0;
        end else begin
            if (dataRe) begin
                if (loadCount >= expLoadCount) begin
                    extraCount++;
                    $display("Unexpected load from address %h after all %0d expected loads",
                             dataAddr, expLoadCount);
                end else if (dataAddr !== expLoadAddr) begin
                    mismatchCount++;
                    $display("Mismatch dataAddr on load %0d: got %h, expected %h",
                             loadCount, dataAddr, expLoadAddr);
                end
                loadCount++;
            end
            if (dataWe) begin
                if (seenCount >= expCount) begin
                    extraCount++;
                    $display("Unexpected store of %h to address %h after all %0d expected stores",
                             dataWrite, dataAddr, expCount);
                end else begin
                    if (dataAddr !== expAddr[seenCount]) begin
                        mismatchCount++;
                        $display("Mismatch dataAddr on store %0d: got %h, expected %h",
                                 seenCount, dataAddr, expAddr[seenCount]);
                    end
                    if (dataWrite !== expData[seenCount]) begin
                        mismatchCount++;
                        $display("Mismatch dataWrite on store %0d: got %h, expected %h",
                                 seenCount, dataWrite, expData[seenCount]);
                    end
                end
                seenCount++;
            end
        end
    end

    assign missingCount = ((seenCount < expCount) ? expCount - seenCount : 0)
                        + ((loadCount < expLoadCount) ? expLoadCount - loadCount : 0);

endmodule

/* verification/tbArmCore.sv */
`include "arm_params.svh"

module tbArmCore;
    import armPkg::*;

    localparam int progLen      = 34;
    localparam int timeoutLimit = 4 * progLen + 50;
    localparam int drainCycles  = 6;
    localparam logic [`WORD_W-1:0] loadMask = 32'hA5A5_0000;
    localparam logic [`WORD_W-1:0] endAddr  = `WORD_W'((progLen - 1) * 4);

    // Data-processing opcodes
    localparam logic [3:0] cmdAnd = 4'h0;
    localparam logic [3:0] cmdSub = 4'h2;
    localparam logic [3:0] cmdAdd = 4'h4;
    localparam logic [3:0] cmdCmp = 4'hA;
    localparam logic [3:0] cmdOrr = 4'hC;
    localparam logic [3:0] cmdMov = 4'hD;

    logic               CLK;
    logic               rstN;
    logic [`WORD_W-1:0] instrAddr;
    instrWord           instr;
    logic [`WORD_W-1:0] dataAddr;
    logic [`WORD_W-1:0] dataWrite;
    logic               dataWe;
    logic               dataRe;
    logic [`WORD_W-1:0] dataRead;

    logic [`WORD_W-1:0] progMem   [progLen];
    logic               storeFlag [progLen];
    logic [`WORD_W-1:0] storeAddr [progLen];
    logic [`WORD_W-1:0] storeData [progLen];
    logic [`WORD_W-1:0] expAddr   [progLen];
    logic [`WORD_W-1:0] expData   [progLen];
    logic [`WORD_W-1:0] expLoadAddr;
    logic [`WORD_W-1:0] fillWord;
    int                 entryCount;
    int                 expCount;
    int                 expLoadCount;
    int                 cycleCount = 0;
    int                 seenCount;
    int                 mismatchCount;
    int                 extraCount;
    int                 missingCount;

    function automatic logic [31:0] dataProc(input logic [3:0] cond, input logic [3:0] cmd,
                                             input logic immBit, input logic sBit,
                                             input logic [3:0] rn, input logic [3:0] rd,
                                             input logic [7:0] op2);
        return {cond, 2'b00, immBit, cmd, sBit, rn, rd, 4'h0, op2};
    endfunction

    // Pre-indexed, offset added, word access
    function automatic logic [31:0] loadStore(input logic [3:0] cond, input logic load,
                                              input logic [3:0] rn, input logic [3:0] rd,
                                              input logic [11:0] imm12);
        return {cond, 2'b01, 2'b01, 3'b100, load, rn, rd, imm12};
    endfunction

    function automatic logic [31:0] branchTo(input logic [3:0] cond, input logic [23:0] offset);
        return {cond, 2'b10, 2'b10, offset};
    endfunction

    task automatic addEntry(input logic [31:0] word, input logic isStore,
                            input logic [31:0] addr, input logic [31:0] data);
        progMem[entryCount]   = word;
        storeFlag[entryCount] = isStore;
        storeAddr[entryCount] = addr;
        storeData[entryCount] = data;
        entryCount++;
    endtask

    task automatic reportCounts();
        $display("Stores seen %0d of %0d, mismatches %0d, missing %0d, unexpected %0d",
                 seenCount, expCount, mismatchCount, missingCount, extraCount);
    endtask

    armCore u_dut (
        .CLK       (CLK),
        .rstN      (rstN),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataWe    (dataWe),
        .dataRe    (dataRe),
        .dataRead  (dataRead)
    );

    coreChecker #(.depth(progLen)) uChecker (
        .CLK           (CLK),
        .rstN          (rstN),
        .dataAddr      (dataAddr),
        .dataWrite     (dataWrite),
        .dataWe        (dataWe),
        .dataRe        (dataRe),
        .expAddr       (expAddr),
        .expData       (expData),
        .expCount      (expCount),
        .expLoadAddr   (expLoadAddr),
        .expLoadCount  (expLoadCount),
        .seenCount     (seenCount),
        .mismatchCount (mismatchCount),
        .extraCount    (extraCount),
        .missingCount  (missingCount)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Fetch and load ports answer in the same cycle
    always_comb begin
        if ((instrAddr >> 2) < progLen) begin
            instr = progMem[instrAddr >> 2];
        end else begin
            instr = fillWord;
        end
    end

    assign dataRead = dataAddr ^ loadMask;

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            $display("Run stopped by timeout after %0d cycles before the end of the program",
                     cycleCount);
            reportCounts();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        logic [`WORD_W-1:0] base;
        logic [`WORD_W-1:0] r1;
        logic [`WORD_W-1:0] r2;
        logic [`WORD_W-1:0] r3;
        logic [`WORD_W-1:0] r4;
        logic [`WORD_W-1:0] r5;
        logic [`WORD_W-1:0] loaded;
        rstN         = 1'b0;
        entryCount   = 0;
        expCount     = 0;
        expLoadCount = 0;
        fillWord     = dataProc(condAl, cmdMov, 1'b1, 1'b0, 4'd0, 4'd12, 8'h00);

        base         = 32'h80;
        r1           = 32'h35;
        r2           = r1 + 32'h0C;
        r3           = r2 - r1;
        r4           = r3 & 32'h0A;
        r5           = r4 | r2;
        expLoadAddr  = base + 32'h200;
        expLoadCount = 1;
        loaded       = expLoadAddr ^ loadMask;

        // Dependent ALU chain, then one store per result
        addEntry(dataProc(condAl, cmdMov, 1'b1, 1'b0, 4'd0, 4'd9, 8'h80), 1'b0, '0, '0);
        addEntry(dataProc(condAl, cmdMov, 1'b1, 1'b0, 4'd0, 4'd1, 8'h35), 1'b0, '0, '0);
        addEntry(dataProc(condAl, cmdAdd, 1'b1, 1'b0, 4'd1, 4'd2, 8'h0C), 1'b0, '0, '0);
        addEntry(dataProc(condAl, cmdSub, 1'b0, 1'b0, 4'd2, 4'd3, 8'h01), 1'b0, '0, '0);
        addEntry(dataProc(condAl, cmdAnd, 1'b1, 1'b0, 4'd3, 4'd4, 8'h0A), 1'b0, '0, '0);
        addEntry(dataProc(condAl, cmdOrr, 1'b0, 1'b0, 4'd4, 4'd5, 8'h02), 1'b0, '0, '0);
        addEntry(dataProc(condAl, cmdMov, 1'b0, 1'b0, 4'd0, 4'd6, 8'h05), 1'b0, '0, '0);
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd2, 12'h000), 1'b1, base, r2);
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd3, 12'h004), 1'b1, base + 32'h04, r3);
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd4, 12'h008), 1'b1, base + 32'h08, r4);
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd5, 12'h00C), 1'b1, base + 32'h0C, r5);
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd6, 12'h010), 1'b1, base + 32'h10, r5);

        // Load with an immediate consumer
        addEntry(loadStore(condAl, 1'b1, 4'd9, 4'd7, 12'h200), 1'b0, '0, '0);
        addEntry(dataProc(condAl, cmdAdd, 1'b1, 1'b0, 4'd7, 4'd8, 8'h11), 1'b0, '0, '0);
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd8, 12'h014), 1'b1, base + 32'h14,
                 loaded + 32'h11);

        // 5 - 7 gives N set, then 5 - 5 gives Z set
        addEntry(dataProc(condAl, cmdMov, 1'b1, 1'b0, 4'd0, 4'd10, 8'h05), 1'b0, '0, '0);
        addEntry(dataProc(condAl, cmdCmp, 1'b1, 1'b1, 4'd10, 4'd0, 8'h07), 1'b0, '0, '0);
        addEntry(loadStore(condEq, 1'b0, 4'd9, 4'd10, 12'h018), 1'b0, '0, '0);
        addEntry(loadStore(condNe, 1'b0, 4'd9, 4'd10, 12'h01C), 1'b1, base + 32'h1C, 32'h5);
        addEntry(loadStore(condLt, 1'b0, 4'd9, 4'd1, 12'h020), 1'b1, base + 32'h20, r1);
        addEntry(loadStore(condGe, 1'b0, 4'd9, 4'd1, 12'h024), 1'b0, '0, '0);
        addEntry(dataProc(condAl, cmdCmp, 1'b1, 1'b1, 4'd10, 4'd0, 8'h05), 1'b0, '0, '0);
        addEntry(loadStore(condEq, 1'b0, 4'd9, 4'd2, 12'h028), 1'b1, base + 32'h28, r2);
        addEntry(loadStore(condGe, 1'b0, 4'd9, 4'd3, 12'h02C), 1'b1, base + 32'h2C, r3);
        addEntry(loadStore(condLt, 1'b0, 4'd9, 4'd3, 12'h030), 1'b0, '0, '0);

        // Taken branch over three stores
        addEntry(branchTo(condAl, 24'd2), 1'b0, '0, '0);
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd1, 12'h034), 1'b0, '0, '0);
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd2, 12'h034), 1'b0, '0, '0);
        // Only reached if the target lands one word short
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd3, 12'h034), 1'b0, '0, '0);
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd4, 12'h034), 1'b1, base + 32'h34, r4);

        // Z still set, so BNE falls through
        addEntry(branchTo(condNe, 24'd1), 1'b0, '0, '0);
        addEntry(loadStore(condAl, 1'b0, 4'd9, 4'd5, 12'h038), 1'b1, base + 32'h38, r5);
        addEntry(dataProc(condAl, cmdMov, 1'b1, 1'b0, 4'd0, 4'd11, 8'h33), 1'b0, '0, '0);
        addEntry(branchTo(condAl, 24'hFF_FFFE), 1'b0, '0, '0);

        for (int i = 0; i < entryCount; i++) begin
            if (storeFlag[i]) begin
                expAddr[expCount] = storeAddr[i];
                expData[expCount] = storeData[i];
                expCount++;
            end
        end

        repeat (4) @(posedge CLK);
        rstN <= 1'b1;

        while (instrAddr != endAddr) begin
            @(posedge CLK);
        end
        // Last store reaches the data port within three cycles of its fetch
        repeat (drainCycles) @(posedge CLK);

        reportCounts();
        if (missingCount > 0) begin
            $display("Program ended with %0d expected accesses never seen", missingCount);
        end
        if (mismatchCount + extraCount + missingCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+common
common/armPkg.sv
rtl/decodeUnit.sv
rtl/regFile.sv
rtl/condUnit.sv
rtl/alu.sv
rtl/hazardUnit.sv
rtl/armCore.sv
verification/coreChecker.sv
verification/tbArmCore.sv

/* run.sh */
#!/bin/sh
# Build and run the armCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tbArmCore -o simv

./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
